// File: Makefile
TOOL      = verilator
FLAGS     = --timing --top-module $(TOP)
TOP       = tag_config_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
hw/tag_pkg.sv
hw/tag_trace_mem.sv
hw/tag_trace_replay.sv
hw/tag_master.sv
hw/tag_client_bank.sv
hw/tag_config_top.sv
verification/tag_config_tb.sv

// File: hw/tag_client_bank.sv
`timescale 1ns/1ps

module tag_client_bank (
  input  logic                                                          clk_i,
  input  logic                                                          rst_i,
  input  logic                                                          wr_v_i,
  input  logic [tag_pkg::client_id_w_lp-1:0]                            wr_client_i,
  input  logic [tag_pkg::payload_w_lp-1:0]                              wr_data_i,
  output logic [tag_pkg::num_clients_lp-1:0][tag_pkg::payload_w_lp-1:0] cfg_o,
  output logic [tag_pkg::num_clients_lp-1:0]                            cfg_update_o
);

  logic [tag_pkg::num_clients_lp-1:0] wr_en;

  // One-hot client select
  always_comb
  begin
    wr_en = '0;
    if (wr_v_i)
    begin
      wr_en[wr_client_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cfg_o        <= '0;
      cfg_update_o <= '0;
    end
    else
    begin
      cfg_update_o <= wr_en;
      for (int i = 0; i < tag_pkg::num_clients_lp; i++)
      begin
        if (wr_en[i])
        begin
          cfg_o[i] <= wr_data_i;
        end
      end
    end
  end

endmodule

// File: hw/tag_config_top.sv
`timescale 1ns/1ps

module tag_config_top (
  input  logic                                                          clk_i,
  input  logic                                                          rst_i,
  input  logic                                                          load_v_i,
  input  logic [tag_pkg::trace_addr_w_lp-1:0]                           load_addr_i,
  input  logic [tag_pkg::trace_word_w_lp-1:0]                           load_data_i,
  input  logic                                                          start_i,
  output logic                                                          busy_o,
  output logic                                                          done_o,
  output logic [tag_pkg::num_clients_lp-1:0][tag_pkg::payload_w_lp-1:0] cfg_o,
  output logic [tag_pkg::num_clients_lp-1:0]                            cfg_update_o
);

  logic [tag_pkg::trace_addr_w_lp-1:0] rd_addr;
  logic [tag_pkg::trace_word_w_lp-1:0] rd_data;

  // Serial tag bus
  logic tag_en;
  logic tag_data;

  logic                               wr_v;
  logic [tag_pkg::client_id_w_lp-1:0] wr_client;
  logic [tag_pkg::payload_w_lp-1:0]   wr_data;

  tag_trace_mem u_trace_mem
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.load_v_i(load_v_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i)
    ,.rd_addr_i(rd_addr), .rd_data_o(rd_data)
    );

  tag_trace_replay u_replay
    (.clk_i(clk_i), .rst_i(rst_i), .start_i(start_i)
    ,.rd_addr_o(rd_addr), .rd_data_i(rd_data)
    ,.tag_en_o(tag_en), .tag_data_o(tag_data)
    ,.busy_o(busy_o), .done_o(done_o)
    );

  tag_master u_master
    (.clk_i(clk_i), .rst_i(rst_i), .tag_en_i(tag_en), .tag_data_i(tag_data)
    ,.wr_v_o(wr_v), .wr_client_o(wr_client), .wr_data_o(wr_data)
    );

  tag_client_bank u_bank
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.wr_v_i(wr_v), .wr_client_i(wr_client), .wr_data_i(wr_data)
    ,.cfg_o(cfg_o), .cfg_update_o(cfg_update_o)
    );

endmodule

// File: hw/tag_master.sv
`timescale 1ns/1ps

module tag_master (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               tag_en_i,
  input  logic                               tag_data_i,
  output logic                               wr_v_o,
  output logic [tag_pkg::client_id_w_lp-1:0] wr_client_o,
  output logic [tag_pkg::payload_w_lp-1:0]   wr_data_o
);

  logic                               en_r;
  logic [tag_pkg::tag_cnt_w_lp-1:0]   bit_idx_r;
  logic [tag_pkg::client_id_w_lp-1:0] client_r;
  logic [tag_pkg::len_w_lp-1:0]       len_r;
  logic [tag_pkg::payload_w_lp-1:0]   data_r;
  logic [tag_pkg::tag_cnt_w_lp-1:0]   pay_idx;
  logic                               pay_bit;

  //////////////////////////////
  // Bit position in the packet
  assign pay_idx = bit_idx_r - tag_pkg::tag_cnt_w_lp'(tag_pkg::tag_hdr_w_lp);

  // Only bits inside the announced length land in the payload
  assign pay_bit = (bit_idx_r >= tag_pkg::tag_cnt_w_lp'(tag_pkg::tag_hdr_w_lp))
                && (pay_idx < tag_pkg::tag_cnt_w_lp'(len_r))
                && (pay_idx < tag_pkg::tag_cnt_w_lp'(tag_pkg::payload_w_lp));

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      en_r      <= 1'b0;
      bit_idx_r <= '0;
    end
    else
    begin
      en_r <= tag_en_i;
      if (tag_en_i)
      begin
        bit_idx_r <= bit_idx_r + 1'b1;
      end
      else
      begin
        bit_idx_r <= '0;
      end
    end
  end

  //////////////////////////////
  // Header and payload capture
  always_ff @(posedge clk_i)
  begin
    if (tag_en_i)
    begin
      if (bit_idx_r == '0)
      begin
        // Start bit clears the previous packet
        client_r <= '0;
        len_r    <= '0;
        data_r   <= '0;
      end
      else if (bit_idx_r <= tag_pkg::tag_cnt_w_lp'(tag_pkg::client_id_w_lp))
      begin
        client_r <= {client_r[tag_pkg::client_id_w_lp-2:0], tag_data_i};
      end
      else if (bit_idx_r < tag_pkg::tag_cnt_w_lp'(tag_pkg::tag_hdr_w_lp))
      begin
        len_r <= {len_r[tag_pkg::len_w_lp-2:0], tag_data_i};
      end
      else if (pay_bit)
      begin
        data_r[pay_idx[$clog2(tag_pkg::payload_w_lp)-1:0]] <= tag_data_i;
      end
    end
  end

  // Falling edge of the enable closes the packet
  assign wr_v_o      = en_r & ~tag_en_i;
  assign wr_client_o = client_r;
  assign wr_data_o   = data_r;

endmodule

// File: hw/tag_pkg.sv
package tag_pkg;

  // Tag bus geometry
  localparam int num_clients_lp  = 4;
  localparam int client_id_w_lp  = 2;
  localparam int payload_w_lp    = 8;
  localparam int len_w_lp        = 4;

  // Start bit, client id and length ahead of the payload
  localparam int tag_hdr_w_lp = 1 + client_id_w_lp + len_w_lp;
  localparam int tag_pkt_w_lp = tag_hdr_w_lp + payload_w_lp;
  localparam int tag_cnt_w_lp = $clog2(tag_pkt_w_lp + 1);

  // Trace memory
  localparam int trace_depth_lp  = 32;
  localparam int trace_addr_w_lp = 5;
  localparam int trace_word_w_lp = 16;
  localparam int wait_w_lp       = 14;

  typedef enum logic [1:0] {
    op_nop  = 2'b00,
    op_send = 2'b01,
    op_wait = 2'b10,
    op_done = 2'b11
  } trace_op_e;

  typedef struct packed {
    logic [client_id_w_lp-1:0] client;
    logic [len_w_lp-1:0]       len;
    logic [payload_w_lp-1:0]   payload;
  } trace_send_s;

  typedef struct packed {
    logic [wait_w_lp-1:0] count;
  } trace_wait_s;

  // Same 14 bits, read per opcode
  typedef union packed {
    trace_send_s send_body;
    trace_wait_s wait_body;
  } trace_body_u;

  typedef struct packed {
    trace_op_e   op;
    trace_body_u body;
  } trace_word_s;

endpackage

// File: hw/tag_trace_mem.sv
`timescale 1ns/1ps

module tag_trace_mem (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                load_v_i,
  input  logic [tag_pkg::trace_addr_w_lp-1:0] load_addr_i,
  input  logic [tag_pkg::trace_word_w_lp-1:0] load_data_i,
  input  logic [tag_pkg::trace_addr_w_lp-1:0] rd_addr_i,
  output logic [tag_pkg::trace_word_w_lp-1:0] rd_data_o
);

  logic [tag_pkg::trace_word_w_lp-1:0] mem_r [tag_pkg::trace_depth_lp];

  // Host load port
  always_ff @(posedge clk_i)
  begin
    if (load_v_i)
    begin
      mem_r[load_addr_i] <= load_data_i;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_data_o <= '0;
    end
    else
    begin
      rd_data_o <= mem_r[rd_addr_i];
    end
  end

endmodule

// File: hw/tag_trace_replay.sv
`timescale 1ns/1ps

module tag_trace_replay (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                start_i,
  output logic [tag_pkg::trace_addr_w_lp-1:0] rd_addr_o,
  input  tag_pkg::trace_word_s                rd_data_i,
  output logic                                tag_en_o,
  output logic                                tag_data_o,
  output logic                                busy_o,
  output logic                                done_o
);

  typedef enum logic [2:0] {s_idle, s_fetch, s_decode, s_shift, s_wait} state_e;

  state_e                               state_r;
  logic [tag_pkg::trace_addr_w_lp-1:0]  addr_r;
  logic [tag_pkg::wait_w_lp-1:0]        cnt_r;
  logic [tag_pkg::tag_pkt_w_lp-1:0]     shift_r;
  logic                                 done_r;

  tag_pkg::trace_send_s                 send_body;
  tag_pkg::trace_wait_s                 wait_body;
  logic [tag_pkg::len_w_lp-1:0]         len_sat;
  logic [tag_pkg::payload_w_lp-1:0]     payload_rev;
  logic                                 last_entry;
  logic                                 op_end;
  logic                                 stop;

  //////////////////////////////
  // Decode of the fetched word
  assign send_body  = rd_data_i.body.send_body;
  assign wait_body  = rd_data_i.body.wait_body;
  assign last_entry = (addr_r == tag_pkg::trace_addr_w_lp'(tag_pkg::trace_depth_lp - 1));

  assign len_sat = (send_body.len > tag_pkg::len_w_lp'(tag_pkg::payload_w_lp))
                 ? tag_pkg::len_w_lp'(tag_pkg::payload_w_lp) : send_body.len;

  // Payload goes out LSB first from an MSB-first shifter
  always_comb
  begin
    for (int i = 0; i < tag_pkg::payload_w_lp; i++)
    begin
      payload_rev[i] = send_body.payload[tag_pkg::payload_w_lp-1-i];
    end
  end

  always_comb
  begin
    op_end = 1'b0;
    if (state_r == s_decode)
    begin
      op_end = (rd_data_i.op == tag_pkg::op_nop)
            || (rd_data_i.op == tag_pkg::op_wait && wait_body.count == '0);
    end
    else if (state_r == s_shift || state_r == s_wait)
    begin
      op_end = (cnt_r == tag_pkg::wait_w_lp'(1));
    end
  end

  assign stop = (state_r == s_decode && rd_data_i.op == tag_pkg::op_done)
             || (op_end && last_entry);

  //////////////////////////////
  // Sequencer
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= s_idle;
      addr_r  <= '0;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end
    else
    begin
      done_r <= stop;
      if (stop)
      begin
        state_r <= s_idle;
      end
      else if (op_end)
      begin
        addr_r  <= addr_r + 1'b1;
        state_r <= s_fetch;
      end
      else
      begin
        case (state_r)
          s_idle:
          begin
            if (start_i)
            begin
              addr_r  <= '0;
              state_r <= s_fetch;
            end
          end
          s_fetch: state_r <= s_decode;
          s_decode:
          begin
            if (rd_data_i.op == tag_pkg::op_send)
            begin
              cnt_r   <= tag_pkg::wait_w_lp'(tag_pkg::tag_hdr_w_lp) + tag_pkg::wait_w_lp'(len_sat);
              state_r <= s_shift;
            end
            else
            begin
              cnt_r   <= wait_body.count;
              state_r <= s_wait;
            end
          end
          default: cnt_r <= cnt_r - 1'b1;
        endcase
      end
    end
  end

  // Packet bits, start bit first
  always_ff @(posedge clk_i)
  begin
    if (state_r == s_decode)
    begin
      shift_r <= {1'b1, send_body.client, len_sat, payload_rev};
    end
    else if (state_r == s_shift)
    begin
      shift_r <= shift_r << 1;
    end
  end

  assign rd_addr_o  = addr_r;
  assign tag_en_o   = (state_r == s_shift);
  assign tag_data_o = shift_r[tag_pkg::tag_pkt_w_lp-1];
  assign busy_o     = (state_r != s_idle);
  assign done_o     = done_r;

endmodule

// File: verification/tag_config_tb.sv
`timescale 1ns/1ps

module tag_config_tb;

  localparam int num_iter_lp     = 40;
  localparam int clk_period_lp   = 100;
  // Worst entry is a fetch and decode, a saturated send and a long wait
  localparam int entry_max_lp    = 2 + 8 + 7 + 20;
  localparam int iter_cycles_lp  = tag_pkg::trace_depth_lp * entry_max_lp
                                 + 2 * tag_pkg::trace_depth_lp;
  localparam int limit_cycles_lp = num_iter_lp * iter_cycles_lp + 200;

  logic                                                          clk_i;
  logic                                                          rst_i;
  logic                                                          load_v_i;
  logic [tag_pkg::trace_addr_w_lp-1:0]                           load_addr_i;
  logic [tag_pkg::trace_word_w_lp-1:0]                           load_data_i;
  logic                                                          start_i;
  logic                                                          busy_o;
  logic                                                          done_o;
  logic [tag_pkg::num_clients_lp-1:0][tag_pkg::payload_w_lp-1:0] cfg_o;
  logic [tag_pkg::num_clients_lp-1:0]                            cfg_update_o;

  logic [15:0] trace_mem [tag_pkg::trace_depth_lp];
  logic [1:0]  exp_client_q [$];
  logic [7:0]  exp_data_q [$];
  logic [7:0]  model_cfg [tag_pkg::num_clients_lp];
  int          exp_cycles;

  tag_config_top u_dut
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.load_v_i(load_v_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i)
    ,.start_i(start_i), .busy_o(busy_o), .done_o(done_o)
    ,.cfg_o(cfg_o), .cfg_update_o(cfg_update_o)
    );

  initial clk_i = 1'b0;
  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      stop_with_failure($sformatf("error: %s actual 0x%0h expected 0x%0h",
                                  name, actual, expected));
    end
  endtask

  //////////////////////////////
  // Trace and reference model
  task automatic build_trace();
    int          pick;
    logic [1:0]  op;
    logic [13:0] body;
    for (int i = 0; i < tag_pkg::trace_depth_lp; i++)
    begin
      pick = $urandom_range(99, 0);
      if (pick < 50)
      begin
        op   = 2'b01;
        body = {2'($urandom), 4'($urandom_range(15, 0)), 8'($urandom)};
      end
      else if (pick < 70)
      begin
        // Junk body that the engine ignores
        op   = 2'b00;
        body = 14'($urandom);
      end
      else if (pick < 97)
      begin
        op   = 2'b10;
        body = 14'($urandom_range(20, 0));
      end
      else
      begin
        op   = 2'b11;
        body = 14'($urandom);
      end
      trace_mem[i] = {op, body};
    end
  endtask

  task automatic run_model();
    logic [1:0]  op;
    logic [13:0] body;
    logic [3:0]  len_sat;
    logic [7:0]  masked;
    exp_cycles = 0;
    for (int i = 0; i < tag_pkg::trace_depth_lp; i++)
    begin
      op   = trace_mem[i][15:14];
      body = trace_mem[i][13:0];
      exp_cycles += 2;
      if (op == 2'b11)
      begin
        break;
      end
      if (op == 2'b01)
      begin
        len_sat = (body[11:8] > 4'd8) ? 4'd8 : body[11:8];
        masked  = body[7:0] & 8'((16'd1 << len_sat) - 16'd1);
        exp_cycles += 7 + int'(len_sat);
        exp_client_q.push_back(body[13:12]);
        exp_data_q.push_back(masked);
        model_cfg[body[13:12]] = masked;
      end
      else if (op == 2'b10)
      begin
        exp_cycles += int'(body);
      end
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  task automatic load_trace();
    for (int i = 0; i < tag_pkg::trace_depth_lp; i++)
    begin
      @(negedge clk_i);
      load_v_i    = 1'b1;
      load_addr_i = tag_pkg::trace_addr_w_lp'(i);
      load_data_i = trace_mem[i];
    end
    @(negedge clk_i);
    load_v_i = 1'b0;
  endtask

  task automatic check_update();
    logic [1:0] exp_client;
    logic [7:0] exp_data;
    if (cfg_update_o != '0)
    begin
      if (exp_client_q.size() == 0)
      begin
        stop_with_failure("an update pulse came when the model expected no more writes");
      end
      exp_client = exp_client_q.pop_front();
      exp_data   = exp_data_q.pop_front();
      check_value("cfg_update_o", 32'(cfg_update_o), 32'(4'b0001 << exp_client));
      check_value($sformatf("cfg_o[%0d]", exp_client), 32'(cfg_o[exp_client]),
                  32'(exp_data));
    end
  endtask

  task automatic run_iteration();
    int cycles;
    build_trace();
    run_model();
    load_trace();
    start_i = 1'b1;
    cycles  = 0;
    while (done_o !== 1'b1)
    begin
      @(negedge clk_i);
      cycles++;
      // Second start while busy is ignored
      start_i = (cycles == 2) ? 1'b1 : 1'b0;
      check_update();
      if (done_o !== 1'b1)
      begin
        check_value("busy_o", 32'(busy_o), 32'd1);
      end
    end
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("done_o latency", 32'(cycles), 32'(exp_cycles + 1));
    // A send at the last entry lands just after done_o
    repeat (4)
    begin
      @(negedge clk_i);
      check_update();
      check_value("done_o", 32'(done_o), 32'd0);
      check_value("busy_o", 32'(busy_o), 32'd0);
    end
    check_value("pending updates", 32'(exp_client_q.size()), 32'd0);
    for (int c = 0; c < tag_pkg::num_clients_lp; c++)
    begin
      check_value($sformatf("cfg_o[%0d]", c), 32'(cfg_o[c]), 32'(model_cfg[c]));
    end
  endtask

  initial
  begin
    void'($urandom(32'haf41));
    rst_i       = 1'b1;
    load_v_i    = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    start_i     = 1'b0;
    for (int c = 0; c < tag_pkg::num_clients_lp; c++)
    begin
      model_cfg[c] = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("done_o", 32'(done_o), 32'd0);
    check_value("cfg_update_o", 32'(cfg_update_o), 32'd0);
    for (int c = 0; c < tag_pkg::num_clients_lp; c++)
    begin
      check_value($sformatf("cfg_o[%0d]", c), 32'(cfg_o[c]), 32'd0);
    end
    for (int n = 0; n < num_iter_lp; n++)
    begin
      run_iteration();
    end
    $display("sim passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(limit_cycles_lp * clk_period_lp);
    stop_with_failure("the run timed out before all trace replays finished");
  end

endmodule
